/* comefa_pkg.sv */
// geometry of the compute RAM array and the bit-serial micro-instruction format
// imported by every module that touches the banks or the instruction memory
package comefa_pkg;

  // four banks, all running the same micro-instruction
  localparam int num_banks  = 4;
  localparam int bank_sel_w = 2;

  // 64 rows of 40 columns per bank, one processing element per column
  localparam int row_w    = 6;
  localparam int num_rows = 1 << row_w;
  localparam int col_w    = 40;

  // 256-word instruction memory
  localparam int instr_addr_w = 8;
  localparam int instr_depth  = 1 << instr_addr_w;

  typedef logic [row_w-1:0]        row_addr_t;
  typedef logic [bank_sel_w-1:0]   bank_sel_t;
  typedef logic [col_w-1:0]        row_data_t;
  typedef logic [instr_addr_w-1:0] instr_addr_t;

  // column operation, applied to every column of every bank at once
  typedef enum logic [2:0] {
    clr_carry = 3'd0,
    copy      = 3'd1,
    op_and    = 3'd2,
    op_or     = 3'd3,
    op_xor    = 3'd4,
    add_c     = 3'd5,
    nop       = 3'd6
  } micro_op_e;

  // sits in bits 20:0 of a stored 32-bit instruction word
  typedef struct packed {
    micro_op_e op;
    row_addr_t dst;
    row_addr_t src_a;
    row_addr_t src_b;
  } micro_inst_t;

  // what the banks see between instructions
  localparam micro_inst_t idle_inst = '{op: nop, dst: '0, src_a: '0, src_b: '0};

endpackage

/* cfu_pkg.sv */
// host command interface of the CFU: command encoding, payload structs, response words
// built on top of the array types in comefa_pkg
package cfu_pkg;

  // host operation, carried in funct3 of the function id
  typedef enum logic [2:0] {
    op_wr_instr = 3'd0,
    op_rd_instr = 3'd1,
    op_wr_row   = 3'd2,
    op_rd_row   = 3'd3,
    op_start    = 3'd4,
    op_status   = 3'd5
  } funct3_e;

  typedef logic [31:0] word_t;

  // one accepted host command
  typedef struct packed {
    funct3_e    funct3;
    logic [6:0] funct7;
    word_t      in0;
    word_t      in1;
  } cmd_t;

  // host access to one row of one bank
  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic                  hi;     // read returns bits 39:32
    comefa_pkg::bank_sel_t bank;
    comefa_pkg::row_addr_t row;
    comefa_pkg::row_data_t data;
  } row_req_t;

  // status word bit positions
  localparam int status_busy = 0;
  localparam int status_done = 1;

  // answer to every command that returns no data
  localparam word_t rsp_ack = '1;

  // funct7 of rd_row that selects the upper part of the row
  localparam logic [6:0] rd_row_hi = 7'd1;

endpackage

/* instr_ram.sv */
`timescale 1ns/100ps
// stored program memory, host port for load and readback, fetch port for the sequencer
// both reads are registered, data one cycle after the address
module instr_ram (
  input  logic                    clk,
  input  logic                    host_we,
  input  comefa_pkg::instr_addr_t host_addr,
  input  logic [31:0]             host_wr_data,
  output logic [31:0]             host_rd_data,
  input  comefa_pkg::instr_addr_t fetch_addr,
  output logic [31:0]             fetch_data
);
  import comefa_pkg::*;

  logic [31:0] mem [instr_depth];

  // host port, read-before-write
  always_ff @(posedge clk) begin
    if (host_we) begin
      mem[host_addr] <= host_wr_data;
    end
    host_rd_data <= mem[host_addr];
  end

  // fetch port, read only
  always_ff @(posedge clk) begin
    fetch_data <= mem[fetch_addr];
  end

endmodule

/* exec_sequencer.sv */
`timescale 1ns/100ps
// steps through the stored program from start to end address and issues one
// micro-instruction per cycle to the banks, fetch of n+1 overlapping issue of n
module exec_sequencer (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    start_pulse,
  input  comefa_pkg::instr_addr_t start_addr,
  input  comefa_pkg::instr_addr_t end_addr,
  output comefa_pkg::instr_addr_t fetch_addr,
  input  cfu_pkg::word_t          fetch_data,
  output logic                    issue_valid,
  output comefa_pkg::micro_inst_t issue_inst,
  output logic                    busy,
  output logic                    done
);
  import comefa_pkg::*;

  // fetch while fetch_ptr points at an unfetched word, run while the last one drains
  typedef enum logic [1:0] {idle, fetch, run} state_e;

  state_e      state;
  instr_addr_t fetch_ptr;
  instr_addr_t end_q;

  assign fetch_addr = fetch_ptr;
  // upper bits of the stored word are spare
  assign issue_inst = micro_inst_t'(fetch_data[$bits(micro_inst_t)-1:0]);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state       <= idle;
      fetch_ptr   <= '0;
      end_q       <= '0;
      issue_valid <= 1'b0;
      busy        <= 1'b0;
      done        <= 1'b0;
    end else begin
      case (state)
        idle: begin
          issue_valid <= 1'b0;
          if (start_pulse) begin
            fetch_ptr <= start_addr;
            end_q     <= end_addr;
            busy      <= 1'b1;
            done      <= 1'b0;
            // empty range finishes without a fetch
            state     <= (start_addr <= end_addr) ? fetch : run;
          end
        end
        fetch: begin
          // valid bit follows the word through the memory latency
          issue_valid <= 1'b1;
          // stop on the end address so 255 never wraps
          if (fetch_ptr == end_q) begin
            state <= run;
          end else begin
            fetch_ptr <= fetch_ptr + instr_addr_t'(1);
          end
        end
        run: begin
          // last word issues this cycle, done stays up until the next start
          issue_valid <= 1'b0;
          busy        <= 1'b0;
          done        <= 1'b1;
          state       <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  a_issue_in_busy: assert property (@(posedge clk) disable iff (!resetn)
    issue_valid |-> busy);

endmodule

/* bank_dispatch.sv */
`timescale 1ns/100ps
// write port steering for the bank array
// one-hot bank enables for host row writes, broadcast of the issued micro-instruction
module bank_dispatch (
  input  logic                           clk,
  input  logic                           resetn,
  input  cfu_pkg::row_req_t              row_req,
  input  logic                           issue_valid,
  input  comefa_pkg::micro_inst_t        issue_inst,
  output cfu_pkg::row_req_t              bank_wr,
  output logic [comefa_pkg::num_banks-1:0] bank_we,
  output logic                           exec_valid,
  output comefa_pkg::micro_inst_t        exec_inst
);
  import comefa_pkg::*;

  logic host_wr;

  // an executing instruction wins the write port
  assign host_wr = row_req.valid && row_req.write && !issue_valid;

  always_comb begin
    bank_wr       = row_req;
    bank_wr.valid = host_wr;
  end

  // bank index to one-hot enable
  always_comb begin
    for (int b = 0; b < num_banks; b++) begin
      bank_we[b] = host_wr && (row_req.bank == bank_sel_t'(b));
    end
  end

  // all banks get the same instruction, nop between issues
  assign exec_valid = issue_valid;
  assign exec_inst  = issue_valid ? issue_inst : idle_inst;

  a_host_vs_exec: assert property (@(posedge clk) disable iff (!resetn)
    !(row_req.valid && row_req.write && issue_valid));

endmodule

/* comefa_bank.sv */
`timescale 1ns/100ps
// one compute RAM bank: 64 rows of 40 bits, one bit-serial PE per column
// host writes and executed results share the write port, the read port is registered
module comefa_bank (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    we,
  input  comefa_pkg::row_addr_t   wr_row,
  input  comefa_pkg::row_data_t   wr_data,
  input  comefa_pkg::row_addr_t   rd_row,
  output comefa_pkg::row_data_t   rd_data,
  input  logic                    exec_valid,
  input  comefa_pkg::micro_inst_t exec_inst
);
  import comefa_pkg::*;

  row_data_t mem [num_rows];
  row_data_t carry;        // one latch per column
  row_data_t opa;
  row_data_t opb;
  row_data_t result;
  row_data_t carry_out;
  logic      wr_result;

  // source rows read in the issue cycle
  assign opa = mem[exec_inst.src_a];
  assign opb = mem[exec_inst.src_b];

  // clr_carry and nop leave the rows alone
  assign wr_result = exec_valid &&
                     (exec_inst.op inside {copy, op_and, op_or, op_xor, add_c});

  ////////////////////////////////////////////////////////////////////////////
  // column processing elements
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < col_w; c++) begin
      result[c]    = opa[c];
      carry_out[c] = carry[c];
      case (exec_inst.op)
        op_and:    result[c] = opa[c] & opb[c];
        op_or:     result[c] = opa[c] | opb[c];
        op_xor:    result[c] = opa[c] ^ opb[c];
        add_c: begin
          // full adder with the column's own carry
          result[c]    = opa[c] ^ opb[c] ^ carry[c];
          carry_out[c] = (opa[c] & opb[c]) | (carry[c] & (opa[c] ^ opb[c]));
        end
        clr_carry: carry_out[c] = 1'b0;
        default:   result[c] = opa[c];
      endcase
    end
  end

  // dst written at the end of the issue cycle, next instruction sees it
  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_row] <= wr_data;
    end else if (wr_result) begin
      mem[exec_inst.dst] <= result;
    end
    rd_data <= mem[rd_row];
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      carry <= '0;
    end else if (exec_valid) begin
      carry <= carry_out;
    end
  end

endmodule

/* bank_read_mux.sv */
`timescale 1ns/100ps
// host read path from the bank array
// keeps the requested bank and half, then registers the chosen 32 bits
module bank_read_mux (
  input  logic                  clk,
  input  comefa_pkg::row_data_t rd_data [comefa_pkg::num_banks],
  input  cfu_pkg::row_req_t     row_req,
  output cfu_pkg::word_t        rd_word
);
  import cfu_pkg::*;
  import comefa_pkg::*;

  bank_sel_t bank_q;
  logic      hi_q;
  row_data_t sel;

  // bank output arrives one cycle after the request
  always_ff @(posedge clk) begin
    if (row_req.valid && !row_req.write) begin
      bank_q <= row_req.bank;
      hi_q   <= row_req.hi;
    end
  end

  assign sel = rd_data[bank_q];

  // upper part is bits 39:32, zero extended
  always_ff @(posedge clk) begin
    if (hi_q) begin
      rd_word <= word_t'(sel[col_w-1:$bits(word_t)]);
    end else begin
      rd_word <= sel[$bits(word_t)-1:0];
    end
  end

endmodule

/* cfu_cmd_ctrl.sv */
`timescale 1ns/100ps
// host command front end: takes one command at a time over valid/ready,
// raises the memory, row or start request and returns a single response word
module cfu_cmd_ctrl (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  cfu_pkg::cmd_t           cmd,
  output logic                    rsp_valid,
  input  logic                    rsp_ready,
  output cfu_pkg::word_t          rsp_data,
  output cfu_pkg::row_req_t       row_req,
  input  cfu_pkg::word_t          rd_word,
  output logic                    instr_we,
  output comefa_pkg::instr_addr_t instr_addr,
  output cfu_pkg::word_t          instr_wr_data,
  input  cfu_pkg::word_t          instr_rd_data,
  output logic                    start_pulse,
  output comefa_pkg::instr_addr_t start_addr,
  output comefa_pkg::instr_addr_t end_addr,
  input  logic                    busy,
  input  logic                    done
);
  import cfu_pkg::*;
  import comefa_pkg::*;

  typedef enum logic [1:0] {idle, wait_data, respond} state_e;

  state_e state;
  cmd_t   cmd_q;
  logic   first_q;
  logic   accept;
  logic   is_read;
  logic   req_cycle;
  logic   rsp_load;
  word_t  status_word;
  word_t  rsp_word;

  assign accept    = cmd_valid && cmd_ready;
  // reads wait one extra cycle for the memory or bank output
  assign is_read   = (cmd_q.funct3 == op_rd_instr) || (cmd_q.funct3 == op_rd_row);
  // first cycle after accept, requests to the memory and sequencer go out here
  assign req_cycle = (state == wait_data) && first_q;
  assign rsp_load  = (state == wait_data) && (!is_read || !first_q);

  ////////////////////////////////////////////////////////////////////////////
  // requests
  ////////////////////////////////////////////////////////////////////////////

  // row access leaves in the accept cycle itself
  // bank read plus mux register gives rd_word two cycles later
  always_comb begin
    row_req       = '0;
    row_req.valid = accept && (cmd.funct3 == op_wr_row || cmd.funct3 == op_rd_row);
    row_req.write = (cmd.funct3 == op_wr_row);
    row_req.hi    = (cmd.funct7 == rd_row_hi);
    if (row_req.write) begin
      {row_req.bank, row_req.row} = cmd.in1[15:8];
    end else begin
      {row_req.bank, row_req.row} = cmd.in0[7:0];
    end
    // in1 low byte carries row bits 39:32
    row_req.data = {cmd.in1[7:0], cmd.in0};
  end

  // instruction memory host port, from the registered command
  assign instr_we      = req_cycle && (cmd_q.funct3 == op_wr_instr);
  assign instr_addr    = cmd_q.in0[instr_addr_w-1:0];
  assign instr_wr_data = cmd_q.in1;

  // end address is inclusive
  assign start_pulse = req_cycle && (cmd_q.funct3 == op_start);
  assign start_addr  = cmd_q.in0[instr_addr_w-1:0];
  assign end_addr    = cmd_q.in1[instr_addr_w-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // response word
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    status_word              = '0;
    status_word[status_busy] = busy;
    status_word[status_done] = done;
  end

  // unknown funct3 falls into the default too
  always_comb begin
    case (cmd_q.funct3)
      op_rd_instr: rsp_word = instr_rd_data;
      op_rd_row:   rsp_word = rd_word;
      op_status:   rsp_word = status_word;
      default:     rsp_word = rsp_ack;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= idle;
      cmd_ready <= 1'b1;
      rsp_valid <= 1'b0;
      first_q   <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (accept) begin
            cmd_ready <= 1'b0;
            first_q   <= 1'b1;
            state     <= wait_data;
          end
        end
        wait_data: begin
          first_q <= 1'b0;
          if (rsp_load) begin
            rsp_valid <= 1'b1;
            state     <= respond;
          end
        end
        respond: begin
          // hold the word until the host takes it
          if (rsp_ready) begin
            rsp_valid <= 1'b0;
            cmd_ready <= 1'b1;
            state     <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // command and response payload
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd;
    end
    if (rsp_load) begin
      rsp_data <= rsp_word;
    end
  end

  // the running program owns the banks, host row traffic only while the sequencer is idle
  a_no_row_while_busy: assert property (@(posedge clk) disable iff (!resetn)
    row_req.valid |-> !busy);

endmodule

/* cfu_top.sv */
`timescale 1ns/100ps
// CFU top level: host command port in front of four compute RAM banks
// funct_id is funct7 in bits 9:3 and funct3 in bits 2:0
module cfu_top (
  input  logic           clk,
  input  logic           resetn,
  input  logic           cmd_valid,
  output logic           cmd_ready,
  input  logic [9:0]     cmd_funct_id,
  input  cfu_pkg::word_t cmd_in0,
  input  cfu_pkg::word_t cmd_in1,
  output logic           rsp_valid,
  input  logic           rsp_ready,
  output cfu_pkg::word_t rsp_data
);
  import cfu_pkg::*;
  import comefa_pkg::*;

  cmd_t                 cmd;
  row_req_t             row_req;
  row_req_t             bank_wr;
  word_t                rd_word;
  word_t                instr_rd_data;
  word_t                instr_wr_data;
  word_t                fetch_data;
  logic                 instr_we;
  instr_addr_t          instr_addr;
  instr_addr_t          start_addr;
  instr_addr_t          end_addr;
  instr_addr_t          fetch_addr;
  logic                 start_pulse;
  logic                 busy;
  logic                 done;
  logic                 issue_valid;
  micro_inst_t          issue_inst;
  logic                 exec_valid;
  micro_inst_t          exec_inst;
  logic [num_banks-1:0] bank_we;
  row_data_t            rd_data [num_banks];

  assign cmd = '{funct3: funct3_e'(cmd_funct_id[2:0]), funct7: cmd_funct_id[9:3],
                 in0: cmd_in0, in1: cmd_in1};

  cfu_cmd_ctrl u_cmd_ctrl (
    .clk           (clk),
    .resetn        (resetn),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .cmd           (cmd),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp_data      (rsp_data),
    .row_req       (row_req),
    .rd_word       (rd_word),
    .instr_we      (instr_we),
    .instr_addr    (instr_addr),
    .instr_wr_data (instr_wr_data),
    .instr_rd_data (instr_rd_data),
    .start_pulse   (start_pulse),
    .start_addr    (start_addr),
    .end_addr      (end_addr),
    .busy          (busy),
    .done          (done)
  );

  instr_ram u_instr_ram (
    .clk          (clk),
    .host_we      (instr_we),
    .host_addr    (instr_addr),
    .host_wr_data (instr_wr_data),
    .host_rd_data (instr_rd_data),
    .fetch_addr   (fetch_addr),
    .fetch_data   (fetch_data)
  );

  exec_sequencer u_exec_sequencer (
    .clk         (clk),
    .resetn      (resetn),
    .start_pulse (start_pulse),
    .start_addr  (start_addr),
    .end_addr    (end_addr),
    .fetch_addr  (fetch_addr),
    .fetch_data  (fetch_data),
    .issue_valid (issue_valid),
    .issue_inst  (issue_inst),
    .busy        (busy),
    .done        (done)
  );

  bank_dispatch u_bank_dispatch (
    .clk         (clk),
    .resetn      (resetn),
    .row_req     (row_req),
    .issue_valid (issue_valid),
    .issue_inst  (issue_inst),
    .bank_wr     (bank_wr),
    .bank_we     (bank_we),
    .exec_valid  (exec_valid),
    .exec_inst   (exec_inst)
  );

  // reads go straight from the host request, writes through the dispatcher
  for (genvar i = 0; i < num_banks; i++) begin : g_bank
    comefa_bank u_bank (
      .clk        (clk),
      .resetn     (resetn),
      .we         (bank_we[i]),
      .wr_row     (bank_wr.row),
      .wr_data    (bank_wr.data),
      .rd_row     (row_req.row),
      .rd_data    (rd_data[i]),
      .exec_valid (exec_valid),
      .exec_inst  (exec_inst)
    );
  end

  bank_read_mux u_bank_read_mux (
    .clk     (clk),
    .rd_data (rd_data),
    .row_req (row_req),
    .rd_word (rd_word)
  );

endmodule

/* tb_checker.sv */
`timescale 1ns/100ps
// response checker for the CFU testbench
// queues the expected word of each accepted command, compares it at the response transfer
module tb_checker (
  input  logic           clk,
  input  logic           resetn,
  input  logic           cmd_ready,
  input  logic           rsp_valid,
  input  logic           rsp_ready,
  input  cfu_pkg::word_t rsp_data,
  input  logic           exp_push,
  input  cfu_pkg::word_t exp_word,
  input  logic           exp_poll,
  output logic           match,
  output int             errors,
  output int             responses
);
  import cfu_pkg::*;

  word_t exp_q [$];
  logic  poll_q [$];
  word_t exp;
  logic  poll;
  // response was offered but not taken last cycle
  logic  held;
  word_t held_data;

  always @(posedge clk) begin
    if (!resetn) begin
      errors    = 0;
      responses = 0;
      match     = 1'b0;
      held      = 1'b0;
      held_data = '0;
      exp_q.delete();
      poll_q.delete();
    end else begin
      // one command outstanding, cmd_ready low until its response is taken
      if (cmd_ready !== (exp_q.size() == 0)) begin
        errors++;
        $display("FAILED cmd_ready exp %h got %h", exp_q.size() == 0, cmd_ready);
      end

      if (exp_push) begin
        exp_q.push_back(exp_word);
        poll_q.push_back(exp_poll);
      end

      ////////////////////////////////////////////////////////////////////////
      // response must stay put until rsp_ready
      ////////////////////////////////////////////////////////////////////////
      if (held) begin
        if (!rsp_valid) begin
          errors++;
          $display("response withdrawn before rsp_ready at %0t", $time);
        end else if (rsp_data !== held_data) begin
          errors++;
          $display("FAILED rsp_data held exp %h got %h", held_data, rsp_data);
        end
      end

      ////////////////////////////////////////////////////////////////////////
      // compare on transfer
      ////////////////////////////////////////////////////////////////////////
      if (rsp_valid && rsp_ready) begin
        responses++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("response at %0t with no command pending", $time);
        end else begin
          exp   = exp_q.pop_front();
          poll  = poll_q.pop_front();
          match = (rsp_data === exp);
          // a status poll that misses is simply retried
          if (!match && !poll) begin
            errors++;
            $display("FAILED rsp_data exp %h got %h", exp, rsp_data);
          end
        end
      end

      held      = rsp_valid && !rsp_ready;
      held_data = rsp_data;
    end
  end

endmodule

/* tb_cfu.sv */
`timescale 1ns/100ps
// testbench top for the CFU, replays cfu_trace.txt through the host command port
// tb_checker watches the response side and counts mismatches
module tb_cfu;
  import cfu_pkg::*;

  localparam int          cycles_per_line = 220;
  localparam int          max_polls       = 200;
  localparam logic [31:0] lfsr_seed       = 32'h0339cd6b;

  // one parsed trace line
  typedef struct packed {
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      in0;
    word_t      in1;
    word_t      exp;
    logic       poll;
  } trace_line_t;

  logic        clk;
  logic        resetn;
  logic        cmd_valid;
  logic        cmd_ready;
  logic [9:0]  cmd_funct_id;
  word_t       cmd_in0;
  word_t       cmd_in1;
  logic        rsp_valid;
  logic        rsp_ready;
  word_t       rsp_data;

  // expected side, pushed into the checker queue on accept
  logic        exp_push;
  word_t       exp_word;
  logic        exp_poll;
  logic        match;
  int          chk_errors;
  int          responses;

  trace_line_t trace_q [$];
  logic [31:0] lfsr_state = lfsr_seed;
  int          cycles     = 0;
  int          limit      = 0;
  int          drv_errors = 0;
  int          sent       = 0;

  cfu_top u_dut (
    .clk          (clk),
    .resetn       (resetn),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .cmd_funct_id (cmd_funct_id),
    .cmd_in0      (cmd_in0),
    .cmd_in1      (cmd_in1),
    .rsp_valid    (rsp_valid),
    .rsp_ready    (rsp_ready),
    .rsp_data     (rsp_data)
  );

  tb_checker u_checker (
    .clk       (clk),
    .resetn    (resetn),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data),
    .exp_push  (exp_push),
    .exp_word  (exp_word),
    .exp_poll  (exp_poll),
    .match     (match),
    .errors    (chk_errors),
    .responses (responses)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // run limit scales with the trace length
  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout after %0d cycles, run stopped", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // random response back-pressure
  ////////////////////////////////////////////////////////////////////////////

  // fibonacci taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  task automatic draw_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // trace reader and command driver
  ////////////////////////////////////////////////////////////////////////////

  // lines that do not parse into six hex fields are comments
  task automatic read_trace();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f3;
    logic [31:0] f7;
    logic [31:0] i0;
    logic [31:0] i1;
    logic [31:0] ex;
    logic [31:0] pl;
    trace_line_t t;
    fd = $fopen("cfu_trace.txt", "r");
    if (fd == 0) begin
      drv_errors++;
      $display("could not open cfu_trace.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) > 0) begin
        n = $sscanf(line, "%h %h %h %h %h %h", f3, f7, i0, i1, ex, pl);
        if (n == 6) begin
          t.funct3 = f3[2:0];
          t.funct7 = f7[6:0];
          t.in0    = i0;
          t.in1    = i1;
          t.exp    = ex;
          t.poll   = pl[0];
          trace_q.push_back(t);
        end
      end
    end
    $fclose(fd);
  endtask

  // one command, one response, inputs change on the falling edge only
  task automatic send_line(input trace_line_t t, output logic ok);
    int delay;
    @(negedge clk);
    cmd_funct_id = {t.funct7, t.funct3};
    cmd_in0      = t.in0;
    cmd_in1      = t.in1;
    cmd_valid    = 1'b1;
    while (!cmd_ready) begin
      @(negedge clk);
    end
    // accepted at the next rising edge, expected word goes in with it
    exp_word = t.exp;
    exp_poll = t.poll;
    exp_push = 1'b1;
    @(negedge clk);
    cmd_valid = 1'b0;
    exp_push  = 1'b0;
    sent++;
    draw_bits(2, delay);
    while (!rsp_valid) begin
      @(negedge clk);
    end
    // hold off the response for 0 to 3 cycles
    repeat (delay) @(negedge clk);
    rsp_ready = 1'b1;
    @(negedge clk);
    rsp_ready = 1'b0;
    ok = match;
  endtask

  initial begin
    trace_line_t t;
    logic        ok;
    int          tries;
    resetn       = 1'b0;
    cmd_valid    = 1'b0;
    cmd_funct_id = '0;
    cmd_in0      = '0;
    cmd_in1      = '0;
    rsp_ready    = 1'b0;
    exp_push     = 1'b0;
    exp_word     = '0;
    exp_poll     = 1'b0;
    read_trace();
    if (trace_q.size() == 0) begin
      drv_errors++;
      $display("trace holds no commands");
    end
    limit = trace_q.size() * cycles_per_line;
    repeat (10) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    foreach (trace_q[i]) begin
      t = trace_q[i];
      if (t.poll) begin
        // status repeats until it shows the expected word
        tries = 0;
        ok    = 1'b0;
        while (!ok && tries < max_polls) begin
          send_line(t, ok);
          tries++;
        end
        if (!ok) begin
          drv_errors++;
          $display("status did not reach %h within %0d polls", t.exp, max_polls);
        end
      end else begin
        send_line(t, ok);
      end
    end
    repeat (4) @(negedge clk);
    if (responses != sent) begin
      drv_errors++;
      $display("%0d responses seen for %0d commands sent", responses, sent);
    end
    $display("errors: %0d from checker, %0d from driver, %0d commands sent",
             chk_errors, drv_errors, sent);
    if (chk_errors == 0 && drv_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* cfu_trace.txt */
# funct3 funct7 in0 in1 expected poll, all hex, one host command per line
# funct3 0 wr_instr 1 rd_instr 2 wr_row 3 rd_row 4 start 5 status, poll 1 repeats until equal
5 00 00000000 00000000 00000000 0
0 00 00000000 00000000 ffffffff 0
0 00 00000001 00042000 ffffffff 0
0 00 00000002 00083001 ffffffff 0
0 00 00000003 000c4001 ffffffff 0
0 00 00000004 00105001 ffffffff 0
0 00 00000005 00000000 ffffffff 0
0 00 00000006 00146001 ffffffff 0
0 00 00000007 00147140 ffffffff 0
1 00 00000002 00000000 00083001 0
1 00 00000007 00000000 00147140 0
7 00 00000000 00000000 ffffffff 0
2 00 3456789a 00000012 ffffffff 0
2 00 0ff00ff0 000001f0 ffffffff 0
2 00 a5a5a5a5 000040a5 ffffffff 0
2 00 0f0f3c3c 0000413c ffffffff 0
2 00 00ff00ff 000080ff ffffffff 0
2 00 f0f0f0f0 0000810f ffffffff 0
2 00 deadbeef 0000c081 ffffffff 0
2 00 cafe1234 0000c17e ffffffff 0
3 00 00000000 00000000 3456789a 0
3 01 00000000 00000000 00000012 0
3 00 00000041 00000000 0f0f3c3c 0
3 01 00000080 00000000 000000ff 0
3 00 000000c1 00000000 cafe1234 0
3 01 000000c1 00000000 0000007e 0
4 00 00000000 00000004 ffffffff 0
5 00 00000000 00000000 00000002 1
3 00 00000002 00000000 3456789a 0
3 00 00000003 00000000 04500890 0
3 00 00000004 00000000 3ff67ffa 0
3 00 00000005 00000000 3ba6776a 0
3 01 00000005 00000000 000000e2 0
3 01 00000043 00000000 00000024 0
3 00 00000045 00000000 aaaa9999 0
3 00 00000084 00000000 f0fff0ff 0
3 01 000000c2 00000000 00000081 0
3 00 000000c5 00000000 1453acdb 0
4 00 00000005 00000007 ffffffff 0
5 00 00000000 00000000 00000002 1
3 00 00000006 00000000 3ba6776a 0
3 00 00000007 00000000 0ba00760 0
3 01 00000007 00000000 000000e0 0
3 01 00000046 00000000 00000099 0
3 00 00000087 00000000 f000f000 0
3 00 000000c7 00000000 00520010 0

/* project.f */
comefa_pkg.sv
cfu_pkg.sv
instr_ram.sv
exec_sequencer.sv
bank_dispatch.sv
comefa_bank.sv
bank_read_mux.sv
cfu_cmd_ctrl.sv
cfu_top.sv
tb_checker.sv
tb_cfu.sv

/* Makefile */
# Verilator build and run for the CFU testbench

VERILATOR ?= verilator
TOP       ?= tb_cfu
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# a nonzero exit or the fail message in the log fails the run
run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "TEST FAIL" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
